// ==== hdl/audio_settings.svh ====
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

`default_nettype none

//////////////////////////////////////////////////////////////////////
// audio core register map
//////////////////////////////////////////////////////////////////////

// fifo status word, write space top byte, read space bottom byte
`define AUDIO_FIFO_ADDR 32'h0000_3044
`define AUDIO_LEFT_ADDR 32'h0000_3048
`define AUDIO_RIGHT_ADDR 32'h0000_304C

// bus data and address width
`define AUDIO_BUS_WIDTH 32
`define AUDIO_SPACE_WIDTH 8

// write only when write space is above this
`define AUDIO_MIN_WRITE_SPACE 2

//////////////////////////////////////////////////////////////////////
// processing widths and constants
//////////////////////////////////////////////////////////////////////

`define AUDIO_SAMPLE_WIDTH 32
`define AUDIO_ACC_WIDTH 48
`define AUDIO_TONE_WIDTH 4
`define AUDIO_VOL_WIDTH 16

// one pole coefficient is 2^-shift
`define AUDIO_EQ_SHIFT 3
`define AUDIO_EQ_FRAC 16
// spacing of the volume table breakpoints
`define AUDIO_VOL_STEP 60

`default_nettype wire

`endif

// ==== hdl/audio_bus_pkg.sv ====
`include "audio_settings.svh"
`default_nettype none

package audio_bus_pkg;

	// master side of the level until ack bus
	typedef struct packed {
		logic [`AUDIO_BUS_WIDTH-1:0] address;
		// held high until ack
		logic read;
		logic write;
		logic [`AUDIO_BUS_WIDTH-1:0] wdata;
	} bus_req_t;

	// slave side, rdata valid in the ack cycle
	typedef struct packed {
		logic ack;
		logic [`AUDIO_BUS_WIDTH-1:0] rdata;
	} bus_rsp_t;

	// status register layout, msb first
	typedef struct packed {
		logic [`AUDIO_SPACE_WIDTH-1:0] write_space;
		logic [`AUDIO_SPACE_WIDTH-1:0] spare_hi;
		logic [`AUDIO_SPACE_WIDTH-1:0] spare_lo;
		// zero when the input fifo is empty
		logic [`AUDIO_SPACE_WIDTH-1:0] read_space;
	} fifo_status_t;

	// same read word, status or data register view
	typedef union packed {
		logic signed [`AUDIO_BUS_WIDTH-1:0] sample;
		fifo_status_t status;
	} bus_rdata_u;

endpackage

`default_nettype wire

// ==== hdl/audio_dsp_pkg.sv ====
`include "audio_settings.svh"
`default_nettype none

package audio_dsp_pkg;

	// one channel word as read from the core
	typedef logic signed [`AUDIO_SAMPLE_WIDTH-1:0] sample_t;

	// filter state, sample plus fraction bits
	typedef logic signed [`AUDIO_ACC_WIDTH-1:0] acc_t;

	// treble gain and bass gain, both two's complement
	typedef struct packed {
		logic signed [`AUDIO_TONE_WIDTH-1:0] treble;
		logic signed [`AUDIO_TONE_WIDTH-1:0] bass;
	} tone_t;

endpackage

`default_nettype wire

// ==== hdl/stream_sequencer.sv ====
`include "audio_settings.svh"
`default_nettype none

module stream_sequencer (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic pause_key,
	input wire logic access_done,
	input wire logic [`AUDIO_SPACE_WIDTH-1:0] write_space,
	input wire logic [`AUDIO_SPACE_WIDTH-1:0] read_space,
	output logic start_status_read,
	output logic start_left_write,
	output logic start_right_write,
	output logic start_left_read,
	output logic start_right_read,
	output logic eq_step,
	output logic paused
);

	typedef enum logic [3:0] {
		ST_STATUS_W,
		ST_CHECK_W,
		ST_FILTER,
		ST_LEFT_W,
		ST_RIGHT_W,
		ST_STATUS_R,
		ST_CHECK_R,
		ST_LEFT_R,
		ST_RIGHT_R
	} state_e;

	state_e state;
	state_e state_next;
	// request raised and not yet acked
	logic req_pending;
	logic issue;
	logic [1:0] pause_sync;
	logic pause_seen;

	//////////////////////////////////////////////////////////////////////
	// pause key
	//////////////////////////////////////////////////////////////////////

	// two flop sync, third flop for edge detect
	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			pause_sync <= '0;
			pause_seen <= 1'b0;
			paused <= 1'b0;
		end else begin
			pause_sync <= {pause_sync[0], pause_key};
			pause_seen <= pause_sync[1];
			// each press flips freeze on or off
			if (pause_sync[1] && !pause_seen)
				paused <= ~paused;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// round sequence
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			ST_STATUS_W: if (access_done) state_next = ST_CHECK_W;
			// room for one more stereo pair
			ST_CHECK_W: begin
				if (write_space > `AUDIO_SPACE_WIDTH'(`AUDIO_MIN_WRITE_SPACE))
					state_next = ST_FILTER;
				else
					state_next = ST_STATUS_W;
			end
			ST_FILTER: state_next = ST_LEFT_W;
			ST_LEFT_W: if (access_done) state_next = ST_RIGHT_W;
			ST_RIGHT_W: if (access_done) state_next = ST_STATUS_R;
			ST_STATUS_R: if (access_done) state_next = ST_CHECK_R;
			// input fifo empty, skip the data reads
			ST_CHECK_R: begin
				if (read_space != '0)
					state_next = ST_LEFT_R;
				else
					state_next = ST_STATUS_W;
			end
			ST_LEFT_R: if (access_done) state_next = ST_RIGHT_R;
			ST_RIGHT_R: if (access_done) state_next = ST_STATUS_W;
			default: state_next = ST_STATUS_W;
		endcase
	end

	// first cycle of a bus state raises its request
	assign issue = !req_pending && !paused;

	assign start_status_read = issue && (state == ST_STATUS_W || state == ST_STATUS_R);
	assign start_left_write = issue && state == ST_LEFT_W;
	assign start_right_write = issue && state == ST_RIGHT_W;
	assign start_left_read = issue && state == ST_LEFT_R;
	assign start_right_read = issue && state == ST_RIGHT_R;
	// filter advances once per written pair
	assign eq_step = !paused && state == ST_FILTER;

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			state <= ST_STATUS_W;
			req_pending <= 1'b0;
		end else if (!paused) begin
			state <= state_next;
			if (start_status_read || start_left_write || start_right_write ||
				start_left_read || start_right_read)
				req_pending <= 1'b1;
			else if (access_done)
				req_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bus_port.sv ====
`include "audio_settings.svh"
`default_nettype none

module bus_port (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic paused,
	input wire logic start_status_read,
	input wire logic start_left_write,
	input wire logic start_right_write,
	input wire logic start_left_read,
	input wire logic start_right_read,
	input wire logic [`AUDIO_BUS_WIDTH-1:0] wdata,
	input wire audio_bus_pkg::bus_rsp_t bus_rsp,
	output audio_bus_pkg::bus_req_t bus_req,
	output logic access_done,
	output logic [`AUDIO_SPACE_WIDTH-1:0] write_space,
	output logic [`AUDIO_SPACE_WIDTH-1:0] read_space,
	output audio_dsp_pkg::sample_t sample
);

	import audio_bus_pkg::*;

	// what to keep from the read word on ack
	typedef enum logic [1:0] {CAP_NONE, CAP_WSPACE, CAP_RSPACE, CAP_SAMPLE} capture_e;

	logic [`AUDIO_BUS_WIDTH-1:0] req_addr;
	logic [`AUDIO_BUS_WIDTH-1:0] req_wdata;
	logic req_read;
	logic req_write;
	capture_e capture;
	// next status read reports read space
	logic after_write;
	bus_rdata_u rdata_view;

	assign rdata_view = bus_rsp.rdata;
	// ack ignored while frozen, request stays up
	assign access_done = bus_rsp.ack && (req_read || req_write) && !paused;

	assign bus_req = '{address: req_addr, read: req_read, write: req_write, wdata: req_wdata};

	// address and data only move when a command starts
	always_ff @(posedge CLOCK_50) begin
		if (start_status_read)
			req_addr <= `AUDIO_FIFO_ADDR;
		else if (start_left_write || start_left_read)
			req_addr <= `AUDIO_LEFT_ADDR;
		else if (start_right_write || start_right_read)
			req_addr <= `AUDIO_RIGHT_ADDR;
		// same word to both channels
		if (start_left_write || start_right_write)
			req_wdata <= wdata;
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			req_read <= 1'b0;
			req_write <= 1'b0;
			capture <= CAP_NONE;
			after_write <= 1'b0;
			write_space <= '0;
			read_space <= '0;
			sample <= '0;
		end else begin
			// drop the level on the ack edge
			if (access_done) begin
				req_read <= 1'b0;
				req_write <= 1'b0;
				case (capture)
					CAP_WSPACE: write_space <= rdata_view.status.write_space;
					CAP_RSPACE: read_space <= rdata_view.status.read_space;
					CAP_SAMPLE: sample <= rdata_view.sample;
					default: ;
				endcase
			end
			if (start_status_read || start_left_read || start_right_read)
				req_read <= 1'b1;
			if (start_left_write || start_right_write)
				req_write <= 1'b1;
			// left read word only keeps the core fifos aligned
			if (start_status_read) begin
				capture <= after_write ? CAP_RSPACE : CAP_WSPACE;
				after_write <= 1'b0;
			end else if (start_right_read) begin
				capture <= CAP_SAMPLE;
			end else if (start_left_read || start_left_write || start_right_write) begin
				capture <= CAP_NONE;
			end
			if (start_right_write)
				after_write <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/volume_scaler.sv ====
`include "audio_settings.svh"
`default_nettype none

module volume_scaler (
	input wire audio_dsp_pkg::sample_t sample,
	input wire logic vol_enable,
	input wire logic [`AUDIO_VOL_WIDTH-1:0] volume,
	output audio_dsp_pkg::sample_t scaled
);

	logic [3:0] shift;

	// attenuation table, one step per breakpoint
	always_comb begin
		if (volume == '0)
			shift = 4'd11;
		else if (volume < `AUDIO_VOL_STEP)
			shift = 4'd9;
		else if (volume < 2 * `AUDIO_VOL_STEP)
			shift = 4'd8;
		else if (volume < 3 * `AUDIO_VOL_STEP)
			shift = 4'd7;
		else if (volume < 4 * `AUDIO_VOL_STEP)
			shift = 4'd6;
		else if (volume < 5 * `AUDIO_VOL_STEP)
			shift = 4'd5;
		else if (volume < 6 * `AUDIO_VOL_STEP)
			shift = 4'd4;
		else if (volume < 7 * `AUDIO_VOL_STEP)
			shift = 4'd2;
		// full level
		else
			shift = 4'd0;
	end

	// arithmetic shift keeps the sign
	assign scaled = vol_enable ? (sample >>> shift) : sample;

endmodule

`default_nettype wire

// ==== hdl/tone_equalizer.sv ====
`include "audio_settings.svh"
`default_nettype none

module tone_equalizer (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic paused,
	input wire logic eq_step,
	input wire audio_dsp_pkg::sample_t scaled,
	input wire audio_dsp_pkg::tone_t tone,
	output logic [`AUDIO_BUS_WIDTH-1:0] eq_word,
	output logic signed [15:0] sound_out
);

	import audio_dsp_pkg::*;

	// two cascaded one pole low pass states
	acc_t without_treble;
	acc_t bass_only;
	acc_t out_acc;

	acc_t x_in;
	acc_t wt_next;
	acc_t treble_only;
	acc_t bass_next;
	acc_t treble_gain;
	acc_t bass_gain;

	// everything 48 bit, overflow wraps
	always_comb begin
		x_in = {scaled, `AUDIO_EQ_FRAC'(0)};
		wt_next = without_treble + ((x_in - without_treble) >>> `AUDIO_EQ_SHIFT);
		// high band is what the first stage removed
		treble_only = x_in - wt_next;
		bass_next = bass_only + ((wt_next - bass_only) >>> `AUDIO_EQ_SHIFT);
		treble_gain = acc_t'($signed(tone.treble));
		// bass gain of one leaves the low band flat
		bass_gain = acc_t'($signed(tone.bass)) - acc_t'(1);
	end

	always_ff @(posedge CLOCK_50, posedge reset) begin
		if (reset) begin
			without_treble <= '0;
			bass_only <= '0;
			out_acc <= '0;
		end else if (eq_step && !paused) begin
			without_treble <= wt_next;
			bass_only <= bass_next;
			out_acc <= wt_next + treble_only * treble_gain + bass_next * bass_gain;
		end
	end

	// integer part to the bus, low half to the monitor output
	assign eq_word = out_acc[47:16];
	assign sound_out = out_acc[31:16];

endmodule

`default_nettype wire

// ==== hdl/audio_fifo_master.sv ====
`default_nettype none

module audio_fifo_master (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic pause_key,
	input wire logic vol_enable,
	input wire logic [15:0] volume,
	input wire audio_dsp_pkg::tone_t tone,
	input wire audio_bus_pkg::bus_rsp_t bus_rsp,
	output audio_bus_pkg::bus_req_t bus_req,
	output logic signed [15:0] sound_out
);

	import audio_dsp_pkg::*;

	// sequencer to bus port commands
	logic start_status_read;
	logic start_left_write;
	logic start_right_write;
	logic start_left_read;
	logic start_right_read;
	logic access_done;
	logic eq_step;
	logic paused;
	logic [7:0] write_space;
	logic [7:0] read_space;
	// datapath, last right word through volume and tone
	sample_t sample;
	sample_t scaled;
	logic [31:0] eq_word;

	stream_sequencer i_sequencer (
		.CLOCK_50(CLOCK_50), .reset(reset), .pause_key(pause_key),
		.access_done(access_done), .write_space(write_space), .read_space(read_space),
		.start_status_read(start_status_read), .start_left_write(start_left_write),
		.start_right_write(start_right_write), .start_left_read(start_left_read),
		.start_right_read(start_right_read), .eq_step(eq_step), .paused(paused)
	);

	bus_port i_bus_port (
		.CLOCK_50(CLOCK_50), .reset(reset), .paused(paused),
		.start_status_read(start_status_read), .start_left_write(start_left_write),
		.start_right_write(start_right_write), .start_left_read(start_left_read),
		.start_right_read(start_right_read), .wdata(eq_word), .bus_rsp(bus_rsp),
		.bus_req(bus_req), .access_done(access_done), .write_space(write_space),
		.read_space(read_space), .sample(sample)
	);

	volume_scaler i_volume (
		.sample(sample), .vol_enable(vol_enable), .volume(volume), .scaled(scaled)
	);

	tone_equalizer i_equalizer (
		.CLOCK_50(CLOCK_50), .reset(reset), .paused(paused), .eq_step(eq_step),
		.scaled(scaled), .tone(tone), .eq_word(eq_word), .sound_out(sound_out)
	);

endmodule

`default_nettype wire

// ==== verif/audio_fifo_master_assert.sv ====
`include "audio_settings.svh"
`default_nettype none

module audio_fifo_master_assert (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic paused,
	input wire audio_bus_pkg::bus_req_t bus_req,
	input wire audio_bus_pkg::bus_rsp_t bus_rsp
);

	timeunit 1ns;
	timeprecision 100ps;

	// number of failed bus checks so far
	int unsigned fail_count = 0;
	logic pending;
	logic done;

	assign pending = bus_req.read || bus_req.write;
	// ack only ends the access while running
	assign done = pending && bus_rsp.ack && !paused;

	one_direction: assert property (@(posedge CLOCK_50) disable iff (reset)
		!(bus_req.read && bus_req.write))
	else begin
		$error("read and write requested together");
		fail_count++;
	end

	// address, data and level held until the ack is taken
	hold_until_ack: assert property (@(posedge CLOCK_50) disable iff (reset)
		pending && !done |=> $stable(bus_req))
	else begin
		$error("request changed while waiting for ack");
		fail_count++;
	end

	drop_on_ack: assert property (@(posedge CLOCK_50) disable iff (reset)
		done |=> !bus_req.read && !bus_req.write)
	else begin
		$error("request still up after its ack");
		fail_count++;
	end

endmodule

// protocol checks on the top level bus
bind audio_fifo_master audio_fifo_master_assert i_assert (
	.CLOCK_50(CLOCK_50), .reset(reset), .paused(paused), .bus_req(bus_req), .bus_rsp(bus_rsp)
);

`default_nettype wire

// ==== verif/tb_audio_fifo_master.sv ====
`include "audio_settings.svh"
`default_nettype none

module tb_audio_fifo_master;

	timeunit 1ns;
	timeprecision 100ps;

	import audio_bus_pkg::*;
	import audio_dsp_pkg::*;

	localparam int CLK_NS = 40;
	localparam int ROUNDS = 20;
	localparam int ROUND_CYCLES = 40;
	// twice the longest expected run
	localparam int WATCHDOG_NS = 2 * ROUNDS * ROUND_CYCLES * CLK_NS;
	localparam int PAIRS = 12;
	localparam int CHECK_W = $bits(bus_req_t);

	// one finished bus access as the bus model saw it
	typedef struct packed {
		logic write;
		logic [31:0] address;
		logic [31:0] data;
		logic [15:0] sound;
	} access_t;

	typedef enum int {
		EXP_STATUS_W, EXP_LEFT_W, EXP_RIGHT_W, EXP_STATUS_R, EXP_LEFT_R, EXP_RIGHT_R
	} expect_e;

	logic CLOCK_50;
	logic reset;
	logic pause_key;
	logic vol_enable;
	logic [15:0] volume;
	tone_t tone;
	bus_rsp_t bus_rsp;
	bus_req_t bus_req;
	logic signed [15:0] sound_out;

	integer seed = 32'h0bbb_7548;
	// write space high byte and read space low byte per status read
	logic [15:0] status_script [0:5] = '{16'h0207, 16'h0105, 16'h0503, 16'h0900, 16'h0301,
		16'h0404};
	logic [15:0] vol_levels [0:4] = '{16'd0, 16'd59, 16'd200, 16'd419, 16'd500};
	int status_idx = 0;
	int ack_wait = 0;
	int pairs_done = 0;
	access_t in_flight;
	access_t done_q [$];
	event access_seen;
	bus_req_t frozen;
	// reference low pass states
	logic signed [47:0] ref_lp1;
	logic signed [47:0] ref_lp2;

	audio_fifo_master i_dut (
		.CLOCK_50(CLOCK_50), .reset(reset), .pause_key(pause_key), .vol_enable(vol_enable),
		.volume(volume), .tone(tone), .bus_rsp(bus_rsp), .bus_req(bus_req),
		.sound_out(sound_out)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_NS / 2) CLOCK_50 = ~CLOCK_50;
	end

	task automatic check_value(input logic [CHECK_W-1:0] actual,
		input logic [CHECK_W-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("RESULT: FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_kind(input access_t acc, input logic write,
		input logic [31:0] address, input string what);
		check_value(acc.write, write, {what, " direction"});
		check_value(acc.address, address, {what, " address"});
	endtask

	// held long enough for the two flop synchronizer
	task automatic press_pause();
		pause_key = 1'b1;
		repeat (3) @(posedge CLOCK_50);
		#2;
		pause_key = 1'b0;
	endtask

	function automatic logic [31:0] status_word(input int idx);
		logic [15:0] pair;
		pair = (idx < 6) ? status_script[idx] : 16'h0902;
		return {pair[15:8], 16'h0000, pair[7:0]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model of volume table and two pole tone mix
	//////////////////////////////////////////////////////////////////////

	function automatic logic signed [47:0] reference_output(input logic signed [31:0] smp,
		input logic en, input logic [15:0] level, input tone_t t);
		int shift_table [0:6] = '{9, 8, 7, 6, 5, 4, 2};
		int shift;
		logic signed [31:0] v;
		logic signed [47:0] x;
		logic signed [47:0] hi;
		logic signed [47:0] tr;
		logic signed [47:0] bs;
		if (!en)
			shift = 0;
		else if (level == 16'd0)
			shift = 11;
		else if (level / `AUDIO_VOL_STEP < 7)
			shift = shift_table[level / `AUDIO_VOL_STEP];
		else
			shift = 0;
		v = smp >>> shift;
		x = {v, 16'h0000};
		ref_lp1 = ref_lp1 + ((x - ref_lp1) >>> `AUDIO_EQ_SHIFT);
		hi = x - ref_lp1;
		ref_lp2 = ref_lp2 + ((ref_lp1 - ref_lp2) >>> `AUDIO_EQ_SHIFT);
		tr = 48'($signed(t.treble));
		bs = 48'($signed(t.bass)) - 48'sd1;
		return ref_lp1 + hi * tr + ref_lp2 * bs;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// bus model acking 1 to 4 cycles after a request shows
	//////////////////////////////////////////////////////////////////////

	initial begin
		bus_rsp = '0;
		forever begin
			@(posedge CLOCK_50);
			#2;
			if (bus_rsp.ack) begin
				bus_rsp.ack = 1'b0;
				// a dropped level ends the access
				// still up means the master is frozen
				if (!bus_req.read && !bus_req.write) begin
					in_flight.sound = sound_out;
					done_q.push_back(in_flight);
					if (!in_flight.write && in_flight.address == `AUDIO_FIFO_ADDR)
						status_idx++;
					->access_seen;
				end
			end else if (bus_req.read || bus_req.write) begin
				if (ack_wait == 0)
					ack_wait = 1 + ($unsigned($random(seed)) % 4);
				ack_wait--;
				if (ack_wait == 0) begin
					in_flight.write = bus_req.write;
					in_flight.address = bus_req.address;
					if (bus_req.write)
						in_flight.data = bus_req.wdata;
					else if (bus_req.address == `AUDIO_FIFO_ADDR)
						in_flight.data = status_word(status_idx);
					else
						in_flight.data = $random(seed);
					bus_rsp.rdata = in_flight.data;
					bus_rsp.ack = 1'b1;
				end
			end
		end
	end

	// access order and every written word against the reference
	initial begin
		access_t acc;
		expect_e step;
		logic signed [31:0] cur_sample;
		logic signed [47:0] ref_out;
		step = EXP_STATUS_W;
		cur_sample = '0;
		ref_lp1 = '0;
		ref_lp2 = '0;
		ref_out = '0;
		forever begin
			while (done_q.size() == 0)
				@(access_seen);
			acc = done_q.pop_front();
			case (step)
				EXP_STATUS_W: begin
					check_kind(acc, 1'b0, `AUDIO_FIFO_ADDR, "write space status read");
					if (acc.data[31:24] > `AUDIO_MIN_WRITE_SPACE) begin
						ref_out = reference_output(cur_sample, vol_enable, volume, tone);
						step = EXP_LEFT_W;
					end
				end
				EXP_LEFT_W: begin
					check_kind(acc, 1'b1, `AUDIO_LEFT_ADDR, "left write");
					check_value(acc.data, ref_out[47:16], "left write data");
					step = EXP_RIGHT_W;
				end
				EXP_RIGHT_W: begin
					check_kind(acc, 1'b1, `AUDIO_RIGHT_ADDR, "right write");
					check_value(acc.data, ref_out[47:16], "right write data");
					check_value(acc.sound, ref_out[31:16], "sound_out");
					pairs_done++;
					step = EXP_STATUS_R;
				end
				EXP_STATUS_R: begin
					check_kind(acc, 1'b0, `AUDIO_FIFO_ADDR, "read space status read");
					if (acc.data[7:0] != 8'd0)
						step = EXP_LEFT_R;
					else
						step = EXP_STATUS_W;
				end
				EXP_LEFT_R: begin
					check_kind(acc, 1'b0, `AUDIO_LEFT_ADDR, "left read");
					step = EXP_RIGHT_R;
				end
				default: begin
					check_kind(acc, 1'b0, `AUDIO_RIGHT_ADDR, "right read");
					cur_sample = acc.data;
					step = EXP_STATUS_W;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		pause_key = 1'b0;
		vol_enable = 1'b0;
		volume = 16'd0;
		tone = '{treble: 4'sd3, bass: 4'sd2};
		repeat (4) @(posedge CLOCK_50);
		#2;
		reset = 1'b0;
		check_value({bus_req.read, bus_req.write}, '0, "request levels after reset");
		// new level lands well before the next filter step
		wait (pairs_done == 3);
		vol_enable = 1'b1;
		foreach (vol_levels[i]) begin
			volume = vol_levels[i];
			wait (pairs_done == 4 + i);
		end
		@(posedge CLOCK_50);
		#2;
		press_pause();
		@(posedge CLOCK_50);
		#2;
		frozen = bus_req;
		// nothing may move while acks keep arriving
		repeat (20) begin
			@(posedge CLOCK_50);
			#2;
			check_value(bus_req, frozen, "bus_req while paused");
		end
		press_pause();
		wait (pairs_done == PAIRS);
		repeat (2) @(posedge CLOCK_50);
		if (i_dut.i_assert.fail_count != 0) begin
			$display("bus protocol checks failed %0d times", i_dut.i_assert.fail_count);
			$display("RESULT: FAIL");
			$fatal(1, "bus protocol violated");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// bound bus protocol checker
	initial begin
		wait (i_dut.i_assert.fail_count != 0);
		$display("bus protocol check failed at %0t ns", $time);
		$display("RESULT: FAIL");
		$fatal(1, "bus protocol violated");
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish, %0d pairs written", pairs_done);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/audio_bus_pkg.sv
hdl/audio_dsp_pkg.sv
hdl/stream_sequencer.sv
hdl/bus_port.sv
hdl/volume_scaler.sv
hdl/tone_equalizer.sv
hdl/audio_fifo_master.sv
verif/audio_fifo_master_assert.sv
verif/tb_audio_fifo_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_audio_fifo_master
DUT_TOP ?= audio_fifo_master
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
